/* hw/scdPkg.sv */
`default_nettype none

package scdPkg;

  // Bit 0 is the most significant bit throughout
  parameter int wordWidth  = 36;
  parameter int expWidth   = 10;
  parameter int magicWidth = 9;

  typedef logic [0:wordWidth-1] word_t;
  typedef logic [0:expWidth-1]  exp_t;

  // Code order follows the microword SCAD field
  typedef enum logic [2:0] {
    funcA,
    funcAMinusBMinus1,
    funcAPlusB,
    funcAMinus1,
    funcAPlus1,
    funcAMinusB,
    funcOr,
    funcAnd
  } scadFunc_e;

  typedef enum logic [1:0] {aFe, aArExp, aArPos, aMagic} scadaSel_e;
  typedef enum logic [1:0] {bSc, bArShift, bArExp, bMagic} scadbSel_e;
  typedef enum logic [1:0] {feHold, feLoad, feShift, feClear} feOp_e;
  typedef enum logic [1:0] {scHold, scFromFe, scFromScad, scFromAr} scOp_e;

  typedef struct packed {
    scadFunc_e              scadFunc;
    scadaSel_e              scadaSel;
    scadbSel_e              scadbSel;
    feOp_e                  feOp;
    scOp_e                  scOp;
    logic                   setAdFlags;
    logic                   expTest;
    logic                   loadFlags;
    logic                   clrFpd;
    logic [0:magicWidth-1]  magic;
  } scdMicro_t;

  // Flags from the main adder
  typedef struct packed {
    logic overflow;
    logic cry0;
    logic cry1;
  } adResult_t;

  typedef struct packed {
    logic ov;
    logic cry0;
    logic cry1;
    logic fov;
    logic fxu;
    logic divChk;
    logic fpd;
  } flags_t;

endpackage

`default_nettype wire

/* hw/scadOperandSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module scadOperandSelect (
  input  scdPkg::scadaSel_e            scadaSel,
  input  scdPkg::scadbSel_e            scadbSel,
  input  logic [0:scdPkg::magicWidth-1] magic,
  input  scdPkg::exp_t                 fe,
  input  scdPkg::exp_t                 sc,
  input  scdPkg::word_t                ar,
  output scdPkg::exp_t                 scadA,
  output scdPkg::exp_t                 scadB
);

  // AR exponent, ones-complemented when the word is negative
  logic [0:7] arExpMag;

  assign arExpMag = ar[1:8] ^ {8{ar[0]}};

  always_comb begin
    case (scadaSel)
      scdPkg::aFe: begin
        scadA = fe;
      end
      scdPkg::aArExp: begin
        scadA = {2'b00, arExpMag};
      end
      scdPkg::aArPos: begin
        scadA = {4'b0000, ar[0:5]};
      end
      default: begin
        // Magic is sign-extended by one bit
        scadA = {magic[0], magic};
      end
    endcase
  end

  always_comb begin
    case (scadbSel)
      scdPkg::bSc: begin
        scadB = sc;
      end
      scdPkg::bArShift: begin
        scadB = {4'b0000, ar[6:11]};
      end
      scdPkg::bArExp: begin
        scadB = {1'b0, ar[0:8]};
      end
      default: begin
        scadB = {1'b0, magic};
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/scadAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module scadAlu (
  input  scdPkg::scadFunc_e func,
  input  scdPkg::exp_t      scadA,
  input  scdPkg::exp_t      scadB,
  output scdPkg::exp_t      scad,
  output logic              scadZero
);

  // All arithmetic wraps modulo 1024
  always_comb begin
    case (func)
      scdPkg::funcA: begin
        scad = scadA;
      end
      scdPkg::funcAMinusBMinus1: begin
        scad = scadA + ~scadB;
      end
      scdPkg::funcAPlusB: begin
        scad = scadA + scadB;
      end
      scdPkg::funcAMinus1: begin
        scad = scadA - 10'd1;
      end
      scdPkg::funcAPlus1: begin
        scad = scadA + 10'd1;
      end
      scdPkg::funcAMinusB: begin
        scad = scadA - scadB;
      end
      scdPkg::funcOr: begin
        scad = scadA | scadB;
      end
      default: begin
        scad = scadA & scadB;
      end
    endcase
  end

  assign scadZero = (scad == '0);

endmodule

`default_nettype wire

/* hw/shiftCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module shiftCounter (
  input  logic              clk,
  input  logic              rstN,
  input  scdPkg::scOp_e     scOp,
  input  scdPkg::exp_t      fe,
  input  scdPkg::exp_t      scad,
  input  scdPkg::word_t     ar,
  output scdPkg::exp_t      sc,
  output logic              scOver63
);

  scdPkg::exp_t scNext;

  // Counting is done through the SCAD, this only picks the new value
  always_comb begin
    case (scOp)
      scdPkg::scFromFe: begin
        scNext = fe;
      end
      scdPkg::scFromScad: begin
        scNext = scad;
      end
      scdPkg::scFromAr: begin
        // AR bit 18 acts as the sign of the shift count
        scNext = {ar[18], ar[18], ar[28:35]};
      end
      default: begin
        scNext = sc;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sc <= '0;
    end else begin
      sc <= scNext;
    end
  end

  assign scOver63 = |sc[0:3];

endmodule

`default_nettype wire

/* hw/floatExponent.sv */
`timescale 1ns/1ps
`default_nettype none

module floatExponent (
  input  logic              clk,
  input  logic              rstN,
  input  scdPkg::feOp_e     feOp,
  input  scdPkg::exp_t      scad,
  output scdPkg::exp_t      fe
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fe <= '0;
    end else begin
      case (feOp)
        scdPkg::feLoad: begin
          fe <= scad;
        end
        scdPkg::feShift: begin
          // Arithmetic shift keeps the sign
          fe <= {fe[0], fe[0:8]};
        end
        scdPkg::feClear: begin
          fe <= '0;
        end
        default: begin
          fe <= fe;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/arithFlags.sv */
`timescale 1ns/1ps
`default_nettype none

module arithFlags (
  input  logic              clk,
  input  logic              rstN,
  input  logic              setAdFlags,
  input  logic              expTest,
  input  logic              loadFlags,
  input  logic              clrFpd,
  input  scdPkg::adResult_t ad,
  input  scdPkg::exp_t      scad,
  input  scdPkg::word_t     ar,
  output scdPkg::flags_t    flags
);

  scdPkg::flags_t flagsNext;
  logic           expOverflow;
  logic           expUnderflow;

  // SCAD bit 1 flags exponent overflow, bit 0 underflow
  assign expOverflow  = expTest & scad[1];
  assign expUnderflow = expTest & scad[0];

  always_comb begin
    if (loadFlags) begin
      flagsNext.ov     = ar[0];
      flagsNext.cry0   = ar[1];
      flagsNext.cry1   = ar[2];
      flagsNext.fov    = ar[3];
      flagsNext.fpd    = ar[4];
      flagsNext.fxu    = ar[11];
      flagsNext.divChk = ar[12];
    end else begin
      // Sticky, new events only add to what is already set
      flagsNext.ov     = flags.ov | (setAdFlags & ad.overflow) | expOverflow;
      flagsNext.cry0   = flags.cry0 | (setAdFlags & ad.cry0);
      flagsNext.cry1   = flags.cry1 | (setAdFlags & ad.cry1);
      flagsNext.fov    = flags.fov | expOverflow;
      flagsNext.fxu    = flags.fxu | expUnderflow;
      flagsNext.divChk = flags.divChk;
      flagsNext.fpd    = flags.fpd & ~clrFpd;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;
    end
  end

endmodule

`default_nettype wire

/* hw/scd.sv */
`timescale 1ns/1ps
`default_nettype none

module scd (
  input  logic              clk,
  input  logic              rstN,
  input  scdPkg::scdMicro_t micro,
  input  scdPkg::word_t     ar,
  input  scdPkg::adResult_t ad,
  output scdPkg::exp_t      fe,
  output scdPkg::exp_t      sc,
  output scdPkg::exp_t      scad,
  output logic              scadZero,
  output logic              scOver63,
  output scdPkg::flags_t    flags
);

  scdPkg::exp_t scadA;
  scdPkg::exp_t scadB;

  scadOperandSelect operandSel (
    .scadaSel (micro.scadaSel),
    .scadbSel (micro.scadbSel),
    .magic    (micro.magic),
    .fe       (fe),
    .sc       (sc),
    .ar       (ar),
    .scadA    (scadA),
    .scadB    (scadB)
  );

  scadAlu alu (
    .func     (micro.scadFunc),
    .scadA    (scadA),
    .scadB    (scadB),
    .scad     (scad),
    .scadZero (scadZero)
  );

  shiftCounter scReg (
    .clk      (clk),
    .rstN     (rstN),
    .scOp     (micro.scOp),
    .fe       (fe),
    .scad     (scad),
    .ar       (ar),
    .sc       (sc),
    .scOver63 (scOver63)
  );

  floatExponent feReg (
    .clk  (clk),
    .rstN (rstN),
    .feOp (micro.feOp),
    .scad (scad),
    .fe   (fe)
  );

  arithFlags flagReg (
    .clk        (clk),
    .rstN       (rstN),
    .setAdFlags (micro.setAdFlags),
    .expTest    (micro.expTest),
    .loadFlags  (micro.loadFlags),
    .clrFpd     (micro.clrFpd),
    .ad         (ad),
    .scad       (scad),
    .ar         (ar),
    .flags      (flags)
  );

endmodule

`default_nettype wire

/* sim/scdAssertions.sv */
`timescale 1ns/1ps
`default_nettype none

module scdAssertions (
  input logic              clk,
  input logic              rstN,
  input scdPkg::scdMicro_t micro,
  input scdPkg::word_t     ar,
  input scdPkg::exp_t      fe,
  input scdPkg::exp_t      sc,
  input scdPkg::flags_t    flags
);

  flagsAfterReset: assert property (@(posedge clk) $rose(rstN) |-> (flags == '0))
    else $error("Flags not zero in the first cycle after reset");

  // Flag load takes AR bit 0 into ov
  flagLoadOv: assert property (@(posedge clk) disable iff (!rstN)
    micro.loadFlags |=> (flags.ov == $past(ar[0])))
    else $error("Flag load did not copy AR bit 0 into ov");

  feClearZero: assert property (@(posedge clk) disable iff (!rstN)
    (micro.feOp == scdPkg::feClear) |=> (fe == '0))
    else $error("FE not zero after a clear");

  scHoldStable: assert property (@(posedge clk) disable iff (!rstN)
    (micro.scOp == scdPkg::scHold) |=> $stable(sc))
    else $error("SC changed during a hold");

endmodule

bind scd scdAssertions checks (
  .clk   (clk),
  .rstN  (rstN),
  .micro (micro),
  .ar    (ar),
  .fe    (fe),
  .sc    (sc),
  .flags (flags)
);

`default_nettype wire

/* sim/scdTb.sv */
`timescale 1ns/1ps
`default_nettype none

module scdTb;

  localparam int numSteps = 1500;
  // Reset, stimulus and a small margin
  localparam int timeoutCycles = 2000;

  typedef struct packed {
    scdPkg::exp_t   fe;
    scdPkg::exp_t   sc;
    scdPkg::flags_t flags;
    scdPkg::exp_t   scad;
    logic           scadZero;
  } stepResult_t;

  logic              clk;
  logic              rstN;
  scdPkg::scdMicro_t micro;
  scdPkg::word_t     ar;
  scdPkg::adResult_t ad;
  scdPkg::exp_t      fe;
  scdPkg::exp_t      sc;
  scdPkg::exp_t      scad;
  logic              scadZero;
  logic              scOver63;
  scdPkg::flags_t    flags;

  scdPkg::exp_t   modelFe;
  scdPkg::exp_t   modelSc;
  scdPkg::flags_t modelFlags;
  int             checkCount = 0;
  int             cycleCount = 0;

  scd DUT (
    .clk      (clk),
    .rstN     (rstN),
    .micro    (micro),
    .ar       (ar),
    .ad       (ad),
    .fe       (fe),
    .sc       (sc),
    .scad     (scad),
    .scadZero (scadZero),
    .scOver63 (scOver63),
    .flags    (flags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic stepResult_t refStep(input scdPkg::exp_t feNow, input scdPkg::exp_t scNow,
      input scdPkg::flags_t flagsNow, input scdPkg::scdMicro_t m,
      input scdPkg::word_t arNow, input scdPkg::adResult_t adNow);
    stepResult_t r;
    scdPkg::exp_t a;
    scdPkg::exp_t b;
    int res;
    logic [31:0] resBits;
    a = '0;
    b = '0;
    case (m.scadaSel)
      scdPkg::aFe: a = feNow;
      scdPkg::aArExp: for (int i = 1; i <= 8; i++) a[i + 1] = arNow[i] ^ arNow[0];
      scdPkg::aArPos: for (int i = 0; i <= 5; i++) a[i + 4] = arNow[i];
      default: begin
        for (int i = 0; i <= 8; i++) a[i + 1] = m.magic[i];
        a[0] = m.magic[0];
      end
    endcase
    case (m.scadbSel)
      scdPkg::bSc: b = scNow;
      scdPkg::bArShift: for (int i = 6; i <= 11; i++) b[i - 2] = arNow[i];
      scdPkg::bArExp: for (int i = 0; i <= 8; i++) b[i + 1] = arNow[i];
      default: for (int i = 0; i <= 8; i++) b[i + 1] = m.magic[i];
    endcase
    case (m.scadFunc)
      scdPkg::funcA: res = int'(a);
      scdPkg::funcAMinusBMinus1: res = int'(a) - int'(b) - 1;
      scdPkg::funcAPlusB: res = int'(a) + int'(b);
      scdPkg::funcAMinus1: res = int'(a) - 1;
      scdPkg::funcAPlus1: res = int'(a) + 1;
      scdPkg::funcAMinusB: res = int'(a) - int'(b);
      scdPkg::funcOr: res = int'(a | b);
      default: res = int'(a & b);
    endcase
    resBits = res & 1023;
    r.scad = resBits[9:0];
    r.scadZero = (resBits == 32'd0);
    case (m.feOp)
      scdPkg::feLoad: r.fe = r.scad;
      scdPkg::feShift: begin
        r.fe[0] = feNow[0];
        for (int i = 1; i <= 9; i++) r.fe[i] = feNow[i - 1];
      end
      scdPkg::feClear: r.fe = '0;
      default: r.fe = feNow;
    endcase
    case (m.scOp)
      scdPkg::scFromFe: r.sc = feNow;
      scdPkg::scFromScad: r.sc = r.scad;
      scdPkg::scFromAr: begin
        r.sc[0] = arNow[18];
        r.sc[1] = arNow[18];
        for (int i = 28; i <= 35; i++) r.sc[i - 26] = arNow[i];
      end
      default: r.sc = scNow;
    endcase
    r.flags = flagsNow;
    if (m.loadFlags) begin
      r.flags.ov = arNow[0];
      r.flags.cry0 = arNow[1];
      r.flags.cry1 = arNow[2];
      r.flags.fov = arNow[3];
      r.flags.fpd = arNow[4];
      r.flags.fxu = arNow[11];
      r.flags.divChk = arNow[12];
    end else begin
      if (m.setAdFlags && adNow.overflow) r.flags.ov = 1'b1;
      if (m.setAdFlags && adNow.cry0) r.flags.cry0 = 1'b1;
      if (m.setAdFlags && adNow.cry1) r.flags.cry1 = 1'b1;
      if (m.expTest && r.scad[1]) begin
        r.flags.ov = 1'b1;
        r.flags.fov = 1'b1;
      end
      if (m.expTest && r.scad[0]) r.flags.fxu = 1'b1;
      if (m.clrFpd) r.flags.fpd = 1'b0;
    end
    return r;
  endfunction

  task automatic checkValue(input string what, input logic [35:0] actual,
      input logic [35:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s mismatch, DUT %0h, expected %0h",
        $time, what, actual, expected);
      $display("Something failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic applyRandomStep();
    logic [31:0] microBits;
    logic [63:0] arBits;
    logic [31:0] adBits;
    microBits = $urandom();
    arBits = {$urandom(), $urandom()};
    adBits = $urandom();
    micro = scdPkg::scdMicro_t'(microBits[$bits(scdPkg::scdMicro_t)-1:0]);
    // Rare flag events keep the sticky flags observable
    micro.setAdFlags = ($urandom_range(7, 0) == 0);
    micro.expTest = ($urandom_range(7, 0) == 0);
    micro.loadFlags = ($urandom_range(15, 0) == 0);
    micro.clrFpd = ($urandom_range(7, 0) == 0);
    ar = arBits[35:0];
    ad = adBits[2:0];
  endtask

  // Outputs are stable at the falling edge, well after the inputs change
  initial begin
    stepResult_t expected;
    forever begin
      @(negedge clk);
      if (!rstN) begin
        modelFe = '0;
        modelSc = '0;
        modelFlags = '0;
      end else begin
        expected = refStep(modelFe, modelSc, modelFlags, micro, ar, ad);
        checkValue("scad", {26'd0, scad}, {26'd0, expected.scad});
        checkValue("scadZero", {35'd0, scadZero}, {35'd0, expected.scadZero});
        checkValue("fe", {26'd0, fe}, {26'd0, modelFe});
        checkValue("sc", {26'd0, sc}, {26'd0, modelSc});
        checkValue("scOver63", {35'd0, scOver63}, {35'd0, (int'(modelSc) > 63)});
        checkValue("flags", {29'd0, flags}, {29'd0, modelFlags});
        modelFe = expected.fe;
        modelSc = expected.sc;
        modelFlags = expected.flags;
        checkCount++;
      end
    end
  end

  initial begin
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Something failed");
    $fatal(1, "Timeout, the run did not finish within %0d cycles", timeoutCycles);
  end

  initial begin
    void'($urandom(32'he8271962));
    rstN = 1'b0;
    micro = '0;
    ar = '0;
    ad = '0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    for (int step = 0; step < numSteps; step++) begin
      applyRandomStep();
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    @(posedge clk);
    if (checkCount >= numSteps) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "Only %0d of %0d steps were compared", checkCount, numSteps);
    end
  end

endmodule

`default_nettype wire

/* build.f */
hw/scdPkg.sv
hw/scadOperandSelect.sv
hw/scadAlu.sv
hw/shiftCounter.sv
hw/floatExponent.sv
hw/arithFlags.sv
hw/scd.sv
sim/scdAssertions.sv
sim/scdTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the scd testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module scdTb -o scdSim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/scdSim; then
  echo "Simulation run failed"
  exit 1
fi

echo "Simulation run completed"
exit 0
